// ==== logic/game_keys_pkg.sv ====
package game_keys_pkg;

   // what a key does in the game
   typedef enum logic [3:0] {
      KEY_NONE,
      KEY_J1_UP,
      KEY_J1_DOWN,
      KEY_J1_LEFT,
      KEY_J1_RIGHT,
      KEY_J1_DROP,
      KEY_J2_UP,
      KEY_J2_DOWN,
      KEY_J2_LEFT,
      KEY_J2_RIGHT,
      KEY_J2_DROP,
      KEY_GAME_OVER
   } key_action_e;

   // held controls of one player
   typedef struct packed {
      logic up;
      logic down;
      logic left;
      logic right;
      logic drop;
   } player_ctrl_t;

   // set-2 make codes of the game keys
   function automatic key_action_e code_to_action(input ps2_pkg::scan_code_t code);
      case (code)
         8'h1D:   return KEY_J1_UP;     // W
         8'h1B:   return KEY_J1_DOWN;   // S
         8'h1C:   return KEY_J1_LEFT;   // A
         8'h23:   return KEY_J1_RIGHT;  // D
         8'h29:   return KEY_J1_DROP;   // space
         8'h44:   return KEY_J2_UP;     // O
         8'h4B:   return KEY_J2_DOWN;   // L
         8'h42:   return KEY_J2_LEFT;   // K
         8'h4C:   return KEY_J2_RIGHT;  // semicolon
         8'h5D:   return KEY_J2_DROP;   // backslash
         8'h5A:   return KEY_GAME_OVER; // enter
         default: return KEY_NONE;
      endcase
   endfunction

endpackage

// ==== logic/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder
  (
   input  logic                        clk,
   input  logic                        reset_n,
   input  ps2_pkg::scan_code_t         code,
   input  logic                        not_empty,
   output logic                        pop,
   output game_keys_pkg::player_ctrl_t j1,
   output game_keys_pkg::player_ctrl_t j2,
   output logic                        game_over
   );

   import ps2_pkg::*;
   import game_keys_pkg::*;

   typedef enum logic {
      ST_MAKE,
      ST_BREAK
   } dec_state_e;

   dec_state_e  state;
   key_action_e action;
   logic        level;

   // one code per cycle, so the buffer drains as fast as it fills
   assign pop = not_empty;

   assign action = code_to_action(code);

   // make sets the bit, a pending break clears it
   assign level = (state == ST_MAKE);

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state     <= ST_MAKE;
         j1        <= '0;
         j2        <= '0;
         game_over <= 1'b0;
      end
      else if (pop)
      begin
         if (code == BREAK_CODE)
            state <= ST_BREAK;
         else if (code != EXT_CODE)
         begin
            // extended prefix is skipped, any other code ends a break
            state <= ST_MAKE;
            case (action)
               KEY_J1_UP:     j1.up     <= level;
               KEY_J1_DOWN:   j1.down   <= level;
               KEY_J1_LEFT:   j1.left   <= level;
               KEY_J1_RIGHT:  j1.right  <= level;
               KEY_J1_DROP:   j1.drop   <= level;
               KEY_J2_UP:     j2.up     <= level;
               KEY_J2_DOWN:   j2.down   <= level;
               KEY_J2_LEFT:   j2.left   <= level;
               KEY_J2_RIGHT:  j2.right  <= level;
               KEY_J2_DROP:   j2.drop   <= level;
               KEY_GAME_OVER: game_over <= level;
               // unmapped keys only consume the break
               default:       ;
            endcase
         end
      end
   end

   // a break prefix is always followed by a key code, never by another break
   a_single_break: assert property (@(posedge clk) disable iff (!reset_n)
      (pop && (code == BREAK_CODE)) |-> (state == ST_MAKE));

endmodule

// ==== logic/keyboard.sv ====
`timescale 1ns/1ps

module keyboard
  (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        ps2_clk,
   input  logic                        ps2_data,
   output game_keys_pkg::player_ctrl_t j1,
   output game_keys_pkg::player_ctrl_t j2,
   output logic                        game_over,
   output logic                        frame_error
   );

   import ps2_pkg::*;

   scan_code_t rx_code;
   logic       rx_push;
   scan_code_t head_code;
   logic       fifo_not_empty;
   logic       dec_pop;

   ps2_receiver u_receiver
     (
      .clk         (clk),
      .reset_n     (reset_n),
      .ps2_clk     (ps2_clk),
      .ps2_data    (ps2_data),
      .code        (rx_code),
      .code_push   (rx_push),
      .frame_error (frame_error)
      );

   // absorbs codes that arrive back to back with their prefixes
   scan_fifo u_fifo
     (
      .clk       (clk),
      .reset_n   (reset_n),
      .wr_code   (rx_code),
      .push      (rx_push),
      .pop       (dec_pop),
      .rd_code   (head_code),
      .not_empty (fifo_not_empty)
      );

   key_decoder u_decoder
     (
      .clk       (clk),
      .reset_n   (reset_n),
      .code      (head_code),
      .not_empty (fifo_not_empty),
      .pop       (dec_pop),
      .j1        (j1),
      .j2        (j2),
      .game_over (game_over)
      );

endmodule

// ==== logic/ps2_pkg.sv ====
package ps2_pkg;

   // one byte as sent by the keyboard
   typedef logic [7:0] scan_code_t;

   // start, 8 data bits lsb first, odd parity, stop
   localparam int FRAME_BITS = 11;
   localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);

   // scan code buffer between receiver and decoder
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // prefixes sent ahead of a key code
   localparam scan_code_t BREAK_CODE = 8'hF0;
   localparam scan_code_t EXT_CODE   = 8'hE0;

   // one frame as it appears on the wire, first bit in bit 0
   typedef struct packed {
      logic       stop;
      logic       parity;
      scan_code_t data;
      logic       start;
   } ps2_frame_t;

endpackage

// ==== logic/ps2_receiver.sv ====
`timescale 1ns/1ps

module ps2_receiver
  (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                ps2_clk,
   input  logic                ps2_data,
   output ps2_pkg::scan_code_t code,
   output logic                code_push,
   output logic                frame_error
   );

   import ps2_pkg::*;

   logic [1:0]            clk_sync;
   logic [1:0]            data_sync;
   logic                  clk_prev;
   logic                  data_bit;
   logic                  fall;

   logic [FRAME_BITS-2:0] shreg;
   logic [BIT_CNT_W-1:0]  bit_cnt;
   logic                  last_bit;
   ps2_frame_t            frame;
   logic                  frame_ok;

   // two flops per line, then the edge register
   // data is delayed by one more flop so it lines up with fall
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
         data_bit  <= 1'b1;
         fall      <= 1'b0;
      end
      else
      begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
         data_bit  <= data_sync[1];
         fall      <= clk_prev & ~clk_sync[1];
      end
   end

   // the 11th bit completes the frame together with the 10 already stored
   assign last_bit = fall && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
   assign frame    = ps2_frame_t'({data_bit, shreg});

   // start low, stop high, odd parity over data and parity bit
   assign frame_ok = !frame.start && frame.stop && (^{frame.data, frame.parity});

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         shreg       <= '0;
         bit_cnt     <= '0;
         code_push   <= 1'b0;
         frame_error <= 1'b0;
      end
      else
      begin
         code_push   <= 1'b0;
         frame_error <= 1'b0;
         if (last_bit)
         begin
            code_push   <= frame_ok;
            frame_error <= !frame_ok;
            shreg       <= '0;
            bit_cnt     <= '0;
         end
         else if (fall)
         begin
            // lsb first, so new bits enter at the top
            shreg   <= {data_bit, shreg[FRAME_BITS-2:1]};
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (last_bit)
         code <= frame.data;
   end

   // a finished frame is either good or bad, never both
   a_push_xor_error: assert property (@(posedge clk) disable iff (!reset_n)
      !(code_push && frame_error));

endmodule

// ==== logic/scan_fifo.sv ====
`timescale 1ns/1ps

module scan_fifo
  (
   input  logic                clk,
   input  logic                reset_n,
   input  ps2_pkg::scan_code_t wr_code,
   input  logic                push,
   input  logic                pop,
   output ps2_pkg::scan_code_t rd_code,
   output logic                not_empty
   );

   import ps2_pkg::*;

   scan_code_t            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic                  full;
   logic                  do_push;
   logic                  do_pop;

   assign full      = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
   assign not_empty = (count != '0);

   // a push into a full buffer is lost
   assign do_push = push && !full;
   assign do_pop  = pop && not_empty;

   // head entry is always visible
   assign rd_code = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= wr_code;
   end

   // depth is a power of two, pointers wrap on their own
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
      push |-> !full);

   a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
      pop |-> not_empty);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_keyboard -Mdir obj_dir -f vlog.f \
   && ./obj_dir/Vtb_keyboard > sim.log \
   && grep -qx "TEST OK" sim.log \
   && echo "simulation passed" \
   || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

// ==== verif/key_checker.sv ====
`timescale 1ns/1ps

module key_checker
  (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        ps2_clk,
   input  logic                        ps2_data,
   input  game_keys_pkg::player_ctrl_t j1,
   input  game_keys_pkg::player_ctrl_t j2,
   input  logic                        game_over,
   input  logic                        frame_error,
   output int                          value_errors,
   output int                          pulse_errors
   );

   import ps2_pkg::*;
   import game_keys_pkg::*;

   typedef struct packed {
      player_ctrl_t j1;
      player_ctrl_t j2;
      logic         game_over;
      logic         in_break;
   } key_model_t;

   key_model_t            model = '0;
   logic [FRAME_BITS-1:0] wire_bits = '0;
   int                    bit_idx = 0;
   int                    frames_seen = 0;
   int                    frames_checked = 0;
   int                    bad_frames = 0;
   int                    pulses = 0;
   int                    settle_cnt = 0;

   // expected controls after one good scan code
   function automatic key_model_t next_model(input key_model_t m, input scan_code_t c);
      logic lvl;
      lvl = !m.in_break;
      if (c == BREAK_CODE)
         m.in_break = 1'b1;
      else if (c != EXT_CODE)
      begin
         m.in_break = 1'b0;
         case (code_to_action(c))
            KEY_J1_UP:     m.j1.up = lvl;
            KEY_J1_DOWN:   m.j1.down = lvl;
            KEY_J1_LEFT:   m.j1.left = lvl;
            KEY_J1_RIGHT:  m.j1.right = lvl;
            KEY_J1_DROP:   m.j1.drop = lvl;
            KEY_J2_UP:     m.j2.up = lvl;
            KEY_J2_DOWN:   m.j2.down = lvl;
            KEY_J2_LEFT:   m.j2.left = lvl;
            KEY_J2_RIGHT:  m.j2.right = lvl;
            KEY_J2_DROP:   m.j2.drop = lvl;
            KEY_GAME_OVER: m.game_over = lvl;
            default:       ;
         endcase
      end
      return m;
   endfunction

   // frames rebuilt straight from the wire, lsb first
   always @(negedge ps2_clk)
   begin
      wire_bits = {ps2_data, wire_bits[FRAME_BITS-1:1]};
      bit_idx++;
      if (bit_idx == FRAME_BITS)
      begin
         if (!wire_bits[0] && wire_bits[10] && (^wire_bits[9:1]))
            model = next_model(model, wire_bits[8:1]);
         else
            bad_frames++;
         bit_idx = 0;
         frames_seen++;
      end
   end

   task automatic compare_outputs();
      int diff;
      if (j1 !== model.j1)
      begin
         value_errors++;
         $display("ERROR at %0t: j1 is %b, expected %b", $time, j1, model.j1);
      end
      if (j2 !== model.j2)
      begin
         value_errors++;
         $display("ERROR at %0t: j2 is %b, expected %b", $time, j2, model.j2);
      end
      if (game_over !== model.game_over)
      begin
         value_errors++;
         $display("ERROR at %0t: game_over is %b, expected %b", $time, game_over,
                  model.game_over);
      end
      // missing and extra pulses both count
      diff = pulses - bad_frames;
      if (diff != 0)
      begin
         $display("ERROR at %0t: %0d frame_error pulses seen, expected %0d", $time,
                  pulses, bad_frames);
         pulse_errors += (diff > 0) ? diff : -diff;
         pulses = bad_frames;
      end
   endtask

   // compare 20 cycles after each frame, and once shortly after reset
   always @(posedge clk)
   begin
      if (!reset_n)
      begin
         value_errors   = 0;
         pulse_errors   = 0;
         frames_checked = frames_seen;
         settle_cnt     = 5;
      end
      else
      begin
         if (frame_error)
            pulses++;
         if (frames_seen != frames_checked)
         begin
            frames_checked = frames_seen;
            settle_cnt     = 20;
         end
         else if (settle_cnt > 0)
         begin
            settle_cnt--;
            if (settle_cnt == 0)
               compare_outputs();
         end
      end
   end

endmodule

// ==== verif/tb_keyboard.sv ====
`timescale 1ns/1ps

module tb_keyboard;

   import ps2_pkg::*;
   import game_keys_pkg::*;

   // 11 keys pressed then released, 5 overlapping, 5 for corruption, 12 for odd codes
   localparam int DIRECTED_FRAMES = 33 + 15 + 5 + 12;
   localparam int RANDOM_OPS      = 200;
   // a release is two frames, a frame takes 240 cycles including the gap
   localparam int WATCHDOG_CYCLES = (DIRECTED_FRAMES + 2 * RANDOM_OPS) * 300 + 1000;

   logic         clk;
   logic         reset_n;
   logic         ps2_clk;
   logic         ps2_data;
   player_ctrl_t j1;
   player_ctrl_t j2;
   logic         game_over;
   logic         frame_error;
   int           value_errors;
   int           pulse_errors;

   // W S A D space, O L K semicolon backslash, enter
   scan_code_t game_codes[$] = '{8'h1D, 8'h1B, 8'h1C, 8'h23, 8'h29,
                                 8'h44, 8'h4B, 8'h42, 8'h4C, 8'h5D, 8'h5A};
   // Q, E and esc are not game keys
   scan_code_t other_codes[$] = '{8'h15, 8'h24, 8'h76};

   keyboard uut
     (
      .clk         (clk),
      .reset_n     (reset_n),
      .ps2_clk     (ps2_clk),
      .ps2_data    (ps2_data),
      .j1          (j1),
      .j2          (j2),
      .game_over   (game_over),
      .frame_error (frame_error)
      );

   key_checker u_checker
     (
      .clk          (clk),
      .reset_n      (reset_n),
      .ps2_clk      (ps2_clk),
      .ps2_data     (ps2_data),
      .j1           (j1),
      .j2           (j2),
      .game_over    (game_over),
      .frame_error  (frame_error),
      .value_errors (value_errors),
      .pulse_errors (pulse_errors)
      );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // one bit every 20 clk cycles, data set up well before ps2_clk falls
   task automatic send_frame(input scan_code_t code, input logic bad_parity,
                             input logic bad_stop);
      logic [FRAME_BITS-1:0] bits;
      bits = {~bad_stop, ~(^code) ^ bad_parity, code, 1'b0};
      for (int i = 0; i < FRAME_BITS; i++)
      begin
         @(negedge clk) ps2_data = bits[0];
         bits = bits >> 1;
         repeat (5) @(negedge clk);
         ps2_clk = 1'b0;
         repeat (10) @(negedge clk);
         ps2_clk = 1'b1;
         repeat (4) @(negedge clk);
      end
      ps2_data = 1'b1;
      repeat (20) @(negedge clk);
   endtask

   task automatic press_key(input scan_code_t code);
      send_frame(code, 1'b0, 1'b0);
   endtask

   task automatic release_key(input scan_code_t code);
      send_frame(BREAK_CODE, 1'b0, 1'b0);
      send_frame(code, 1'b0, 1'b0);
   endtask

   task automatic random_keys();
      int         pick;
      scan_code_t code;
      for (int n = 0; n < RANDOM_OPS; n++)
      begin
         pick = $urandom_range(0, 13);
         code = (pick < 11) ? game_codes[pick] : other_codes[pick - 11];
         if ($urandom_range(0, 1) == 0)
            press_key(code);
         else
            release_key(code);
      end
   endtask

   initial
   begin
      reset_n  = 1'b0;
      ps2_clk  = 1'b1;
      ps2_data = 1'b1;
      void'($urandom(42));
      repeat (8) @(posedge clk);
      @(negedge clk) reset_n = 1'b1;
      repeat (20) @(negedge clk);

      // every key alone, earlier keys stay held
      foreach (game_codes[i])
         press_key(game_codes[i]);
      foreach (game_codes[i])
         release_key(game_codes[i]);

      // both players at once, released out of order
      press_key(8'h1D);
      press_key(8'h4B);
      press_key(8'h23);
      press_key(8'h5D);
      press_key(8'h5A);
      release_key(8'h5D);
      release_key(8'h1D);
      release_key(8'h5A);
      release_key(8'h23);
      release_key(8'h4B);

      // corrupted frames, then a good enter
      send_frame(8'h5A, 1'b1, 1'b0);
      send_frame(8'h1D, 1'b0, 1'b1);
      press_key(8'h5A);
      release_key(8'h5A);

      // unmapped codes and a lone extended prefix
      press_key(8'h15);
      send_frame(EXT_CODE, 1'b0, 1'b0);
      press_key(8'h75);
      press_key(8'h1B);
      // break eaten by an unmapped key, W must still go down
      release_key(8'h15);
      press_key(8'h1D);
      release_key(8'h1D);
      // extended prefix inside a break must leave the break pending
      send_frame(BREAK_CODE, 1'b0, 1'b0);
      send_frame(EXT_CODE, 1'b0, 1'b0);
      send_frame(8'h1B, 1'b0, 1'b0);

      random_keys();
      repeat (10) @(negedge clk);

      $display("errors: %0d output mismatches, %0d frame_error mismatches",
               value_errors, pulse_errors);
      if (value_errors == 0 && pulse_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired: the key sequences did not finish in time");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
logic/ps2_pkg.sv
logic/game_keys_pkg.sv
logic/ps2_receiver.sv
logic/scan_fifo.sv
logic/key_decoder.sv
logic/keyboard.sv
verif/key_checker.sv
verif/tb_keyboard.sv
